//--- hw/core_pkg.sv
package core_pkg;

    // Access width of loads and stores
    typedef enum logic [1:0] {
        WIDTH_NONE = 2'b00,   // Value written is zero
        WIDTH_BYTE = 2'b01,
        WIDTH_HALF = 2'b10,
        WIDTH_WORD = 2'b11
    } width_e;

    // Bundle from execute into the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] op_c;        // ALU result or store data
        logic [31:0] addr;
        logic [4:0]  reg_waddr;
        logic        reg_we;
        logic        mtype;       // Load
        logic        store;
        width_e      width;
    } exmem_t;

    // MEM/WB register content
    typedef struct packed {
        logic [31:0] op_c;
        logic [4:0]  reg_waddr;
        logic        reg_we;
        logic        mtype;
        width_e      width;
    } memwb_t;

    // Register file write
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] data;
    } wb_write_t;

endpackage

//--- hw/mem_pkg.sv
package mem_pkg;

    // Data memory request, one strobe per access
    typedef struct packed {
        logic                rd;
        logic                wr;
        logic [31:0]         addr;
        logic [31:0]         wdata;   // Store data in the low lanes
        core_pkg::width_e    width;
    } dmem_req_t;

    // Load data comes back shifted down to bit 0
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } dmem_rsp_t;

endpackage

//--- hw/dmem_port.sv
`timescale 1ns/10ps

module dmem_port #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::dmem_req_t  req_i,
    output mem_pkg::dmem_rsp_t  rsp_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   mem_q [DMEM_WORDS];
    logic [AW-1:0] word_idx;
    logic [3:0]    byte_en;
    logic [31:0]   wdata_lanes;
    logic [31:0]   rd_word;
    logic [31:0]   rd_shift;
    logic [31:0]   rd_data;
    logic          rsp_valid_q;
    logic [31:0]   rsp_data_q;

    assign word_idx = req_i.addr[AW+1:2];

    // Lane enables and replicated store data
    always_comb begin
        case (req_i.width)
            core_pkg::WIDTH_BYTE: begin
                byte_en     = 4'b0001 << req_i.addr[1:0];
                wdata_lanes = {4{req_i.wdata[7:0]}};
            end
            core_pkg::WIDTH_HALF: begin
                byte_en     = req_i.addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{req_i.wdata[15:0]}};
            end
            core_pkg::WIDTH_WORD: begin
                byte_en     = 4'b1111;
                wdata_lanes = req_i.wdata;
            end
            default: begin
                byte_en     = 4'b0000;   // No lanes touched
                wdata_lanes = 32'h0;
            end
        endcase
    end

    assign rd_word  = mem_q[word_idx];
    assign rd_shift = rd_word >> {req_i.addr[1:0], 3'b000};

    // Keep only the accessed lanes
    always_comb begin
        case (req_i.width)
            core_pkg::WIDTH_BYTE: rd_data = {24'h0, rd_shift[7:0]};
            core_pkg::WIDTH_HALF: rd_data = {16'h0, rd_shift[15:0]};
            core_pkg::WIDTH_WORD: rd_data = rd_shift;
            default:              rd_data = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_i.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem_q[word_idx][8*i +: 8] <= wdata_lanes[8*i +: 8];
                end
            end
        end
        if (req_i.rd) begin
            rsp_data_q <= rd_data;
        end
    end

    // One-cycle valid pulse after each read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.rd;
        end
    end

    assign rsp_o.valid = rsp_valid_q;
    assign rsp_o.data  = rsp_data_q;

endmodule

//--- hw/mem_wb_reg.sv
`timescale 1ns/10ps

module mem_wb_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::exmem_t  exmem_i,
    input  logic              stall_i,
    input  logic              flush_i,
    output core_pkg::memwb_t  memwb_o
);

    core_pkg::memwb_t memwb_q;
    core_pkg::memwb_t memwb_d;

    // Writeback fields of a valid bundle, otherwise a bubble
    always_comb begin
        memwb_d = '0;
        if (exmem_i.valid) begin
            memwb_d.op_c      = exmem_i.op_c;
            memwb_d.reg_waddr = exmem_i.reg_waddr;
            memwb_d.reg_we    = exmem_i.reg_we;
            memwb_d.mtype     = exmem_i.mtype;
            memwb_d.width     = exmem_i.width;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_q <= '0;
        end else if (stall_i) begin
            memwb_q <= memwb_q;   // Stall wins over flush
        end else if (flush_i) begin
            memwb_q <= '0;
        end else begin
            memwb_q <= memwb_d;
        end
    end

    assign memwb_o = memwb_q;

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::memwb_t     memwb_i,
    input  mem_pkg::dmem_rsp_t   rsp_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    output core_pkg::wb_write_t  wb_o
);

    logic [31:0] buf_q;
    logic        in_buf_q;
    logic [31:0] load_raw;
    logic [31:0] wb_data;

    function automatic logic [31:0] sign_ext(
        input logic [31:0]      data,
        input core_pkg::width_e width
    );
        case (width)
            core_pkg::WIDTH_BYTE: return {{24{data[7]}}, data[7:0]};
            core_pkg::WIDTH_HALF: return {{16{data[15]}}, data[15:0]};
            core_pkg::WIDTH_WORD: return data;
            default:              return 32'h0;
        endcase
    endfunction

    // Response pulse may land while the front end is stalled
    always_ff @(posedge clk) begin
        if (stall_i && rsp_i.valid) begin
            buf_q <= rsp_i.data;
        end else if (stall_i) begin
            buf_q <= buf_q;
        end else if (flush_i) begin
            buf_q <= 32'h0;
        end else begin
            buf_q <= memwb_i.op_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_buf_q <= 1'b0;
        end else if (stall_i && rsp_i.valid) begin
            in_buf_q <= 1'b1;
        end else if (!stall_i && !flush_i) begin
            in_buf_q <= 1'b0;
        end
    end

    assign load_raw = rsp_i.valid ? rsp_i.data : buf_q;

    always_comb begin
        if (memwb_i.mtype) begin
            wb_data = sign_ext(load_raw, memwb_i.width);
        end else begin
            wb_data = memwb_i.op_c;
        end
    end

    // A load writes only once its data has arrived
    assign wb_o.we    = memwb_i.reg_we & (~memwb_i.mtype | rsp_i.valid | in_buf_q);
    assign wb_o.waddr = memwb_i.reg_waddr;
    assign wb_o.data  = wb_data;

endmodule

//--- hw/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::wb_write_t  wr_i,
    input  logic [4:0]           dbg_raddr_i,
    output logic [31:0]          dbg_rdata_o
);

    logic [31:0] regs_q [1:31];   // x0 is not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= 32'h0;
            end
        end else if (wr_i.we && (wr_i.waddr != 5'd0)) begin
            regs_q[wr_i.waddr] <= wr_i.data;
        end
    end

    assign dbg_rdata_o = (dbg_raddr_i == 5'd0) ? 32'h0 : regs_q[dbg_raddr_i];

endmodule

//--- hw/mem_wb_top.sv
`timescale 1ns/10ps

module mem_wb_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::exmem_t     exmem_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  logic [4:0]           dbg_raddr_i,
    output logic [31:0]          dbg_rdata_o,
    output core_pkg::wb_write_t  wb_o
);

    mem_pkg::dmem_req_t   dmem_req;
    mem_pkg::dmem_rsp_t   dmem_rsp;
    core_pkg::memwb_t     memwb;
    core_pkg::wb_write_t  wb_write;

    // No memory access while the stage is held
    assign dmem_req.rd    = exmem_i.valid & exmem_i.mtype & ~stall_i;
    assign dmem_req.wr    = exmem_i.valid & exmem_i.store & ~stall_i;
    assign dmem_req.addr  = exmem_i.addr;
    assign dmem_req.wdata = exmem_i.op_c;
    assign dmem_req.width = exmem_i.width;

    dmem_port #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dmem_port_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (dmem_req),
        .rsp_o (dmem_rsp)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .exmem_i (exmem_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .memwb_o (memwb)
    );

    wb_stage wb_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .memwb_i (memwb),
        .rsp_i   (dmem_rsp),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .wb_o    (wb_write)
    );

    reg_file reg_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wb_write),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

    assign wb_o = wb_write;

endmodule

//--- bench/tb_mem_wb.sv
`timescale 1ns/10ps

module tb_mem_wb;

    localparam int DMEM_WORDS  = 256;
    localparam int AW          = $clog2(DMEM_WORDS);
    localparam int CLK_PERIOD  = 40;
    localparam int N_ALU       = 40;
    localparam int N_MEM       = 60;
    localparam int N_STALL     = 12;
    localparam int N_FLUSH     = 12;
    localparam int N_SST       = 8;
    // Worst case with every stall at its longest
    localparam int TOTAL_CYCLES = 2 + 32 + DMEM_WORDS + (N_ALU + 3) + 2 * N_MEM
                                + 7 * N_STALL + 3 * N_FLUSH + 7 * N_SST + 3 + 32;

    logic                 clk = 1'b0;
    logic                 rst_n;
    core_pkg::exmem_t     exmem_i;
    logic                 stall_i;
    logic                 flush_i;
    logic [4:0]           dbg_raddr_i;
    logic [31:0]          dbg_rdata_o;
    core_pkg::wb_write_t  wb_o;

    core_pkg::wb_write_t  exp_wb;        // Write the model expects on wb_o
    logic [31:0]          shadow_regs [32];
    logic [31:0]          shadow_mem [DMEM_WORDS];
    logic [31:0]          exp_dbg;
    logic [31:0]          dut_word;      // DUT memory word under the current address
    logic [31:0]          model_word;
    logic [4:0]           hist0;
    logic [4:0]           hist1;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_wb_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_wb_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .exmem_i     (exmem_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o),
        .wb_o        (wb_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Lane select and sign extension of a load
    function automatic logic [31:0] load_value(
        input logic [31:0]      word,
        input logic [1:0]       off,
        input core_pkg::width_e w
    );
        logic [31:0] sh;
        sh = word >> {off, 3'b000};
        case (w)
            core_pkg::WIDTH_BYTE: return {{24{sh[7]}}, sh[7:0]};
            core_pkg::WIDTH_HALF: return {{16{sh[15]}}, sh[15:0]};
            core_pkg::WIDTH_WORD: return word;
            default:              return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(
        input logic [31:0]      old,
        input logic [31:0]      data,
        input logic [1:0]       off,
        input core_pkg::width_e w
    );
        logic [31:0] mask;
        logic [31:0] ins;
        case (w)
            core_pkg::WIDTH_BYTE: begin
                mask = 32'h0000_00ff << {off, 3'b000};
                ins  = {24'h0, data[7:0]} << {off, 3'b000};
            end
            core_pkg::WIDTH_HALF: begin
                mask = 32'h0000_ffff << {off[1], 4'b0000};
                ins  = {16'h0, data[15:0]} << {off[1], 4'b0000};
            end
            core_pkg::WIDTH_WORD: begin
                mask = 32'hffff_ffff;
                ins  = data;
            end
            default: begin
                mask = 32'h0;
                ins  = 32'h0;
            end
        endcase
        return (old & ~mask) | ins;
    endfunction

    function automatic logic [31:0] rand_addr(input core_pkg::width_e w);
        logic [31:0] r;
        logic [1:0]  off;
        r = $urandom;
        case (w)
            core_pkg::WIDTH_BYTE: off = r[1:0];
            core_pkg::WIDTH_HALF: off = {r[1], 1'b0};
            default:              off = 2'b00;
        endcase
        return {{(30 - AW){1'b0}}, r[AW+1:2], off};
    endfunction

    function automatic core_pkg::exmem_t alu_bundle(input logic [4:0] rd, input logic [31:0] val);
        core_pkg::exmem_t b;
        b           = '0;
        b.valid     = 1'b1;
        b.op_c      = val;
        b.reg_waddr = rd;
        b.reg_we    = 1'b1;
        b.width     = core_pkg::WIDTH_WORD;
        return b;
    endfunction

    function automatic core_pkg::exmem_t load_bundle(
        input logic [4:0]       rd,
        input logic [31:0]      addr,
        input core_pkg::width_e w
    );
        core_pkg::exmem_t b;
        b           = '0;
        b.valid     = 1'b1;
        b.addr      = addr;
        b.reg_waddr = rd;
        b.reg_we    = 1'b1;
        b.mtype     = 1'b1;
        b.width     = w;
        return b;
    endfunction

    function automatic core_pkg::exmem_t store_bundle(
        input logic [31:0]      addr,
        input logic [31:0]      data,
        input core_pkg::width_e w
    );
        core_pkg::exmem_t b;
        b       = '0;
        b.valid = 1'b1;
        b.op_c  = data;
        b.addr  = addr;
        b.store = 1'b1;
        b.width = w;
        return b;
    endfunction

    // One cycle of stimulus with the debug port two bundles behind
    task automatic drive_cycle(input core_pkg::exmem_t b, input logic stall, input logic flush);
        exmem_i     = b;
        stall_i     = stall;
        flush_i     = flush;
        dbg_raddr_i = hist1;
        if (!stall) begin
            hist1 = hist0;
            hist0 = b.reg_waddr;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 32; i++) begin
            exmem_i     = '0;
            stall_i     = 1'b0;
            flush_i     = 1'b0;
            dbg_raddr_i = 5'(i);
            @(posedge clk);
            #2;
        end
    endtask

    // Reference model updated at each edge from the inputs held during the cycle
    always @(posedge clk or negedge rst_n) begin : model
        logic [AW-1:0]       word;
        logic [1:0]          off;
        core_pkg::wb_write_t nxt;
        if (!rst_n) begin
            exp_wb <= '0;
            for (int i = 0; i < 32; i++) begin
                shadow_regs[i] <= 32'h0;
            end
        end else begin
            if (exp_wb.we && (exp_wb.waddr != 5'd0)) begin
                shadow_regs[exp_wb.waddr] <= exp_wb.data;
            end
            if (!stall_i) begin   // Held bundle waits
                word      = exmem_i.addr[AW+1:2];
                off       = exmem_i.addr[1:0];
                nxt.we    = exmem_i.valid && exmem_i.reg_we && !flush_i;
                nxt.waddr = exmem_i.reg_waddr;
                nxt.data  = exmem_i.mtype ? load_value(shadow_mem[word], off, exmem_i.width)
                                          : exmem_i.op_c;
                exp_wb <= nxt;
                if (exmem_i.valid && exmem_i.store) begin
                    shadow_mem[word] <= store_merge(shadow_mem[word], exmem_i.op_c, off,
                                                    exmem_i.width);
                end
            end
        end
    end

    assign exp_dbg    = shadow_regs[dbg_raddr_i];
    assign dut_word   = mem_wb_top_i.dmem_port_i.mem_q[exmem_i.addr[AW+1:2]];
    assign model_word = shadow_mem[exmem_i.addr[AW+1:2]];

    wb_check: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_o.we == exp_wb.we) &&
        (!exp_wb.we || ((wb_o.waddr == exp_wb.waddr) && (wb_o.data == exp_wb.data))))
    else report_failure($sformatf(
        "Mismatch at %0t: wb_o is we=%0b x%0d=%08h, model expects we=%0b x%0d=%08h",
        $time, $sampled(wb_o.we), $sampled(wb_o.waddr), $sampled(wb_o.data),
        $sampled(exp_wb.we), $sampled(exp_wb.waddr), $sampled(exp_wb.data)));

    dbg_check: assert property (@(posedge clk) disable iff (!rst_n) dbg_rdata_o == exp_dbg)
    else report_failure($sformatf(
        "Mismatch at %0t: x%0d reads %08h on the debug port, model expects %08h",
        $time, $sampled(dbg_raddr_i), $sampled(dbg_rdata_o), $sampled(exp_dbg)));

    // Memory keeps its old word until the held store is accepted
    mem_hold_check: assert property (@(posedge clk) disable iff (!rst_n)
        (exmem_i.valid && exmem_i.store && (stall_i || $past(stall_i))) |->
        (dut_word == model_word))
    else report_failure($sformatf(
        "Mismatch at %0t: word %0d is %08h while the store is held, model expects %08h",
        $time, $sampled(exmem_i.addr[AW+1:2]), $sampled(dut_word), $sampled(model_word)));

    initial begin : watchdog
        #((TOTAL_CYCLES + 50) * CLK_PERIOD);
        report_failure("Watchdog timeout: the stimulus did not finish in time");
    end

    initial begin : stimulus
        core_pkg::exmem_t b;
        core_pkg::width_e w;
        core_pkg::width_e lw;
        logic [31:0]      a;
        logic [31:0]      ta;
        int               n;
        void'($urandom(32'h059fc34d));
        $timeformat(-9, 1, " ns", 0);
        rst_n       = 1'b0;
        exmem_i     = '0;
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        dbg_raddr_i = 5'd0;
        hist0       = 5'd0;
        hist1       = 5'd0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        sweep_regs();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            drive_cycle(store_bundle(32'(i * 4), $urandom, core_pkg::WIDTH_WORD), 1'b0, 1'b0);
        end
        drive_cycle(alu_bundle(5'd0, $urandom), 1'b0, 1'b0);   // x0 stays zero
        repeat (N_ALU) begin
            drive_cycle(alu_bundle(5'($urandom_range(31, 0)), $urandom), 1'b0, 1'b0);
        end
        repeat (2) drive_cycle('0, 1'b0, 1'b0);
        repeat (N_MEM) begin
            w  = core_pkg::width_e'(2'($urandom_range(3, 1)));
            lw = core_pkg::width_e'(2'($urandom_range(3, 0)));
            a  = rand_addr(w);
            ta = rand_addr(lw);
            drive_cycle(store_bundle(a, $urandom, w), 1'b0, 1'b0);
            drive_cycle(load_bundle(5'($urandom_range(31, 1)), {a[31:2], ta[1:0]}, lw),
                        1'b0, 1'b0);
        end
        // Load response lands while the front end is stalled
        repeat (N_STALL) begin
            w = core_pkg::width_e'(2'($urandom_range(3, 1)));
            drive_cycle(load_bundle(5'($urandom_range(31, 1)), rand_addr(w), w), 1'b0, 1'b0);
            n = $urandom_range(5, 1);
            b = alu_bundle(5'($urandom_range(31, 1)), $urandom);
            repeat (n) drive_cycle(b, 1'b1, 1'b0);
            drive_cycle(b, 1'b0, 1'b0);
        end
        repeat (N_FLUSH) begin
            w = core_pkg::width_e'(2'($urandom_range(3, 1)));
            if ($urandom_range(1, 0) == 1) begin
                b = load_bundle(5'($urandom_range(31, 1)), rand_addr(w), w);
            end else begin
                b = alu_bundle(5'($urandom_range(31, 1)), $urandom);
            end
            drive_cycle(b, 1'b0, 1'b1);
            repeat (2) drive_cycle('0, 1'b0, 1'b0);
        end
        // Store held by a stall and then read back
        repeat (N_SST) begin
            w = core_pkg::width_e'(2'($urandom_range(3, 1)));
            a = rand_addr(w);
            b = store_bundle(a, $urandom, w);
            n = $urandom_range(5, 1);
            repeat (n) drive_cycle(b, 1'b1, 1'b0);
            drive_cycle(b, 1'b0, 1'b0);
            drive_cycle(load_bundle(5'($urandom_range(31, 1)), a, w), 1'b0, 1'b0);
        end
        repeat (3) drive_cycle('0, 1'b0, 1'b0);
        sweep_regs();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- build.f
hw/core_pkg.sv
hw/mem_pkg.sv
hw/dmem_port.sv
hw/mem_wb_reg.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/mem_wb_top.sv
bench/tb_mem_wb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_wb -f build.f \
    -o sim_mem_wb > sim.log 2>&1 || { cat sim.log; echo "Build failed"; exit 1; }
./obj_dir/sim_mem_wb 2>&1 | tee -a sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
